// ==== mips_cfg.svh ====
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

`define NB         32                // data path width
`define NB_REGS    5                 // register index width
`define DMEM_WORDS 256               // data memory depth in words
`define HALT_INSTR 32'hFFFF_FFFF     // stop word
`define LINK_REG   5'd31             // return address register

`endif

// ==== isa_pkg.sv ====
`default_nettype none
`include "mips_cfg.svh"

package isa_pkg;
    typedef logic [`NB-1:0]      word_t;
    typedef logic [`NB_REGS-1:0] reg_idx_t;
    typedef logic [5:0]          opcode_t;
    typedef logic [5:0]          funct_t;
    typedef logic [15:0]         imm16_t;
    typedef logic [4:0]          shamt_t;
    typedef logic [25:0]         jidx_t;     // J-type target field

    localparam opcode_t OP_RTYPE = 6'b000000;
    localparam opcode_t OP_J     = 6'b000010;
    localparam opcode_t OP_JAL   = 6'b000011;
    localparam opcode_t OP_BEQ   = 6'b000100;
    localparam opcode_t OP_BNE   = 6'b000101;
    localparam opcode_t OP_ADDI  = 6'b001000;
    localparam opcode_t OP_SLTI  = 6'b001010;
    localparam opcode_t OP_ANDI  = 6'b001100;
    localparam opcode_t OP_ORI   = 6'b001101;
    localparam opcode_t OP_XORI  = 6'b001110;
    localparam opcode_t OP_LUI   = 6'b001111;
    localparam opcode_t OP_LB    = 6'b100000;
    localparam opcode_t OP_LH    = 6'b100001;
    localparam opcode_t OP_LW    = 6'b100011;
    localparam opcode_t OP_LBU   = 6'b100100;
    localparam opcode_t OP_LHU   = 6'b100101;
    localparam opcode_t OP_LWU   = 6'b100111;
    localparam opcode_t OP_SB    = 6'b101000;
    localparam opcode_t OP_SH    = 6'b101001;
    localparam opcode_t OP_SW    = 6'b101011;

    localparam funct_t FN_SLL  = 6'b000000;
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_JR   = 6'b001000;
    localparam funct_t FN_JALR = 6'b001001;
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_SLT  = 6'b101010;
endpackage

`default_nettype wire

// ==== ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;
    import isa_pkg::*;

    typedef enum logic [1:0] {WS_BYTE, WS_HALF, WS_WORD} word_size_t;
    typedef enum logic {EXT_SIGNED, EXT_UNSIGNED} ext_mode_t;
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_t;

    typedef struct packed {
        logic       alu_src;           // 1 picks the immediate
        logic       mem_read;
        logic       mem_write;
        logic       mem_to_reg;
        logic       reg_write;
        reg_idx_t   reg_dir_to_write;
        logic       branch;
        logic       branch_ne;         // bne instead of beq
        logic       jump;
        logic       jr_jalr;
        logic       link;              // write pc+4
        logic       halt;
        logic       load_signed;
        ext_mode_t  ext_mode;
        word_size_t word_size;
        alu_op_t    alu_op;
    } ctrl_t;

    localparam ctrl_t CTRL_NOP = '{
        reg_dir_to_write: '0,
        ext_mode:         EXT_SIGNED,
        word_size:        WS_WORD,
        alu_op:           ALU_ADD,
        default:          1'b0
    };

    typedef struct packed {
        logic   valid;
        word_t  pc;
        word_t  rs_val;
        word_t  rt_val;
        word_t  imm;                   // already extended
        shamt_t shamt;
        jidx_t  jump_idx;
        ctrl_t  ctrl;
    } id_ex_t;

    typedef struct packed {
        logic  valid;
        word_t alu_result;
        word_t store_data;
        word_t link_value;
        ctrl_t ctrl;
    } ex_mem_t;

    typedef struct packed {
        logic     enable;
        reg_idx_t reg_idx;
        word_t    data;
    } wb_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;
endpackage

`default_nettype wire

// ==== control_unit.sv ====
`default_nettype none
`include "mips_cfg.svh"

module control_unit
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  word_t i_instruction,
    output ctrl_t o_ctrl
);
    opcode_t  opcode;
    funct_t   funct;
    reg_idx_t rt;
    reg_idx_t rd;

    assign opcode = i_instruction[31:26];
    assign rt     = i_instruction[20:16];
    assign rd     = i_instruction[15:11];
    assign funct  = i_instruction[5:0];

    always_comb begin
        o_ctrl = CTRL_NOP;
        if (i_instruction == `HALT_INSTR) begin
            o_ctrl.halt = 1'b1;
        end else if (i_instruction != '0) begin   // zero word stays a nop
            case (opcode)
                OP_RTYPE: begin
                    o_ctrl.reg_write        = 1'b1;
                    o_ctrl.reg_dir_to_write = rd;
                    case (funct)
                        FN_ADDU: o_ctrl.alu_op = ALU_ADD;
                        FN_SUBU: o_ctrl.alu_op = ALU_SUB;
                        FN_AND:  o_ctrl.alu_op = ALU_AND;
                        FN_OR:   o_ctrl.alu_op = ALU_OR;
                        FN_XOR:  o_ctrl.alu_op = ALU_XOR;
                        FN_SLT:  o_ctrl.alu_op = ALU_SLT;
                        FN_SLL:  o_ctrl.alu_op = ALU_SLL;
                        FN_SRL:  o_ctrl.alu_op = ALU_SRL;
                        FN_JR: begin
                            o_ctrl.jr_jalr   = 1'b1;   // pc = rs, no write
                            o_ctrl.reg_write = 1'b0;
                        end
                        FN_JALR: begin
                            o_ctrl.jr_jalr          = 1'b1;
                            o_ctrl.link             = 1'b1;
                            o_ctrl.reg_dir_to_write = `LINK_REG;
                        end
                        default: o_ctrl = CTRL_NOP;
                    endcase
                end
                OP_ADDI, OP_SLTI: begin
                    o_ctrl.alu_src          = 1'b1;
                    o_ctrl.reg_write        = 1'b1;
                    o_ctrl.reg_dir_to_write = rt;
                    o_ctrl.alu_op           = (opcode == OP_SLTI) ? ALU_SLT : ALU_ADD;
                end
                OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                    o_ctrl.alu_src          = 1'b1;
                    o_ctrl.ext_mode         = EXT_UNSIGNED;   // logical immediates
                    o_ctrl.reg_write        = 1'b1;
                    o_ctrl.reg_dir_to_write = rt;
                    case (opcode)
                        OP_ANDI: o_ctrl.alu_op = ALU_AND;
                        OP_ORI:  o_ctrl.alu_op = ALU_OR;
                        OP_XORI: o_ctrl.alu_op = ALU_XOR;
                        default: o_ctrl.alu_op = ALU_LUI;
                    endcase
                end
                OP_BEQ, OP_BNE: begin
                    o_ctrl.branch    = 1'b1;
                    o_ctrl.branch_ne = (opcode == OP_BNE);
                    o_ctrl.alu_op    = ALU_SUB;
                end
                OP_J: o_ctrl.jump = 1'b1;
                OP_JAL: begin
                    o_ctrl.jump             = 1'b1;
                    o_ctrl.link             = 1'b1;
                    o_ctrl.reg_write        = 1'b1;
                    o_ctrl.reg_dir_to_write = `LINK_REG;
                end
                OP_SB, OP_SH, OP_SW: begin
                    o_ctrl.alu_src   = 1'b1;   // base + offset
                    o_ctrl.mem_write = 1'b1;
                    o_ctrl.word_size = (opcode == OP_SB) ? WS_BYTE :
                                       (opcode == OP_SH) ? WS_HALF : WS_WORD;
                end
                OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWU: begin
                    o_ctrl.alu_src          = 1'b1;
                    o_ctrl.mem_read         = 1'b1;
                    o_ctrl.mem_to_reg       = 1'b1;
                    o_ctrl.reg_write        = 1'b1;
                    o_ctrl.reg_dir_to_write = rt;
                    o_ctrl.load_signed      = (opcode == OP_LB) || (opcode == OP_LH) ||
                                              (opcode == OP_LW);
                    o_ctrl.word_size        = (opcode == OP_LB || opcode == OP_LBU) ? WS_BYTE :
                                              (opcode == OP_LH || opcode == OP_LHU) ? WS_HALF :
                                              WS_WORD;
                end
                default: o_ctrl = CTRL_NOP;
            endcase
        end
    end

    // only one kind of pc change per instruction
    ctrl_flow_onehot: assert final ($onehot0({o_ctrl.branch, o_ctrl.jump, o_ctrl.jr_jalr}));
endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`default_nettype none
`include "mips_cfg.svh"

module decode_stage
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  word_t     i_instruction,
    input  word_t     i_pc,
    input  logic      i_flush,
    input  redirect_t i_redirect,
    input  wb_t       i_wb,
    input  logic      i_halted,
    output id_ex_t    o_id_ex
);
    ctrl_t    ctrl;
    reg_idx_t rs;
    reg_idx_t rt;
    imm16_t   imm;
    word_t    imm_ext;
    word_t    rs_val;
    word_t    rt_val;
    logic     squash;
    word_t    regfile [2**`NB_REGS];

    control_unit u_control (
        .i_instruction (i_instruction),
        .o_ctrl        (ctrl)
    );

    assign rs  = i_instruction[25:21];
    assign rt  = i_instruction[20:16];
    assign imm = i_instruction[15:0];

    assign imm_ext = (ctrl.ext_mode == EXT_SIGNED) ? {{(`NB-16){imm[15]}}, imm}
                                                   : {{(`NB-16){1'b0}}, imm};

    // taken redirect kills the sequential instruction behind the jump
    assign squash = i_flush || i_redirect.taken || i_halted;

    always_ff @(posedge i_clk) begin
        if (i_wb.enable && i_wb.reg_idx != '0) begin
            regfile[i_wb.reg_idx] <= i_wb.data;
        end
    end

    // write-through, so a reader two slots behind sees the value
    always_comb begin
        rs_val = regfile[rs];
        rt_val = regfile[rt];
        if (i_wb.enable && i_wb.reg_idx == rs) rs_val = i_wb.data;
        if (i_wb.enable && i_wb.reg_idx == rt) rt_val = i_wb.data;
        if (rs == '0) rs_val = '0;   // r0 hardwired
        if (rt == '0) rt_val = '0;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || squash) begin
            o_id_ex.valid <= 1'b0;
            o_id_ex.ctrl  <= CTRL_NOP;
        end else begin
            o_id_ex.valid <= 1'b1;
            o_id_ex.ctrl  <= ctrl;
        end
        o_id_ex.pc       <= i_pc;
        o_id_ex.rs_val   <= rs_val;
        o_id_ex.rt_val   <= rt_val;
        o_id_ex.imm      <= imm_ext;
        o_id_ex.shamt    <= i_instruction[10:6];
        o_id_ex.jump_idx <= i_instruction[25:0];
    end
endmodule

`default_nettype wire

// ==== execute_stage.sv ====
`default_nettype none
`include "mips_cfg.svh"

module execute_stage
    import ctrl_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  id_ex_t    i_id_ex,
    output ex_mem_t   o_ex_mem,
    output redirect_t o_redirect
);
    ctrl_t           ctrl;
    logic [`NB-1:0]  op_a;
    logic [`NB-1:0]  op_b;
    logic [`NB-1:0]  alu_result;
    logic [`NB-1:0]  pc_plus4;
    logic [`NB-1:0]  branch_target;
    logic [`NB-1:0]  jump_target;
    logic            operands_equal;
    redirect_t       redirect_next;

    assign ctrl = i_id_ex.ctrl;
    assign op_a = i_id_ex.rs_val;
    assign op_b = ctrl.alu_src ? i_id_ex.imm : i_id_ex.rt_val;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_SLT: alu_result = {{(`NB-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLL: alu_result = i_id_ex.rt_val << i_id_ex.shamt;
            ALU_SRL: alu_result = i_id_ex.rt_val >> i_id_ex.shamt;
            ALU_LUI: alu_result = {op_b[15:0], 16'b0};
            default: alu_result = '0;
        endcase
    end

    assign pc_plus4       = i_id_ex.pc + 4;
    assign branch_target  = pc_plus4 + {i_id_ex.imm[`NB-3:0], 2'b00};
    assign jump_target    = {pc_plus4[`NB-1:`NB-4], i_id_ex.jump_idx, 2'b00};
    assign operands_equal = (i_id_ex.rs_val == i_id_ex.rt_val);

    always_comb begin
        redirect_next.taken  = 1'b0;
        redirect_next.target = branch_target;
        if (i_id_ex.valid) begin
            if (ctrl.branch && (operands_equal != ctrl.branch_ne)) begin
                redirect_next.taken = 1'b1;
            end else if (ctrl.jump) begin
                redirect_next.taken  = 1'b1;
                redirect_next.target = jump_target;
            end else if (ctrl.jr_jalr) begin
                redirect_next.taken  = 1'b1;
                redirect_next.target = i_id_ex.rs_val;   // register target
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_redirect.taken <= 1'b0;
            o_ex_mem.valid   <= 1'b0;
            o_ex_mem.ctrl    <= CTRL_NOP;
        end else begin
            o_redirect.taken <= redirect_next.taken;
            o_ex_mem.valid   <= i_id_ex.valid;
            o_ex_mem.ctrl    <= ctrl;
        end
        o_redirect.target   <= redirect_next.target;
        o_ex_mem.alu_result <= alu_result;
        o_ex_mem.store_data <= i_id_ex.rt_val;
        o_ex_mem.link_value <= pc_plus4;   // return address
    end

    // a squashed slot must never steer the fetch unit
    redirect_needs_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_id_ex.valid |=> !o_redirect.taken);
endmodule

`default_nettype wire

// ==== result_stage.sv ====
`default_nettype none
`include "mips_cfg.svh"

module result_stage
    import ctrl_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  ex_mem_t i_ex_mem,
    output wb_t     o_wb,
    output logic    o_halt
);
    localparam int AW = $clog2(`DMEM_WORDS);

    ctrl_t          ctrl;
    logic [AW-1:0]  word_addr;
    logic [1:0]     byte_off;
    logic [3:0]     byte_en;
    logic [`NB-1:0] wdata;
    logic [`NB-1:0] rd_word;
    logic [7:0]     rd_byte;
    logic [15:0]    rd_half;
    logic [`NB-1:0] load_value;
    logic [`NB-1:0] wb_data;
    logic [`NB-1:0] dmem [`DMEM_WORDS];

    assign ctrl      = i_ex_mem.ctrl;
    assign word_addr = i_ex_mem.alu_result[AW+1:2];
    assign byte_off  = i_ex_mem.alu_result[1:0];

    // replicate store data across lanes, enables pick the lane
    always_comb begin
        case (ctrl.word_size)
            WS_BYTE: begin
                byte_en = 4'b0001 << byte_off;
                wdata   = {4{i_ex_mem.store_data[7:0]}};
            end
            WS_HALF: begin
                byte_en = 4'b0011 << {byte_off[1], 1'b0};
                wdata   = {2{i_ex_mem.store_data[15:0]}};
            end
            default: begin
                byte_en = 4'b1111;
                wdata   = i_ex_mem.store_data;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_ex_mem.valid && ctrl.mem_write) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) dmem[word_addr][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    assign rd_word = dmem[word_addr];
    assign rd_byte = rd_word[{byte_off, 3'b000} +: 8];        // little-endian lane
    assign rd_half = rd_word[{byte_off[1], 4'b0000} +: 16];

    always_comb begin
        case (ctrl.word_size)
            WS_BYTE: load_value = {{(`NB-8){ctrl.load_signed & rd_byte[7]}}, rd_byte};
            WS_HALF: load_value = {{(`NB-16){ctrl.load_signed & rd_half[15]}}, rd_half};
            default: load_value = rd_word;
        endcase
    end

    assign wb_data = ctrl.link       ? i_ex_mem.link_value :
                     ctrl.mem_to_reg ? load_value : i_ex_mem.alu_result;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_wb.enable <= 1'b0;
            o_halt      <= 1'b0;
        end else begin
            o_wb.enable <= i_ex_mem.valid && ctrl.reg_write;
            if (i_ex_mem.valid && ctrl.halt) o_halt <= 1'b1;   // sticky until reset
        end
        o_wb.reg_idx <= ctrl.reg_dir_to_write;
        o_wb.data    <= wb_data;
    end

    // decoder never asks for both directions at once
    mem_dir_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_ex_mem.valid |-> !(ctrl.mem_read && ctrl.mem_write));
endmodule

`default_nettype wire

// ==== mips_core.sv ====
`default_nettype none
`include "mips_cfg.svh"

module mips_core
    import ctrl_pkg::*;
(
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic [`NB-1:0] i_instruction,
    input  logic [`NB-1:0] i_pc,
    input  logic           i_flush,
    output wb_t            o_wb,
    output redirect_t      o_redirect,
    output logic           o_halt
);
    id_ex_t  id_ex;
    ex_mem_t ex_mem;

    decode_stage u_decode (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_instruction (i_instruction),
        .i_pc          (i_pc),
        .i_flush       (i_flush),
        .i_redirect    (o_redirect),
        .i_wb          (o_wb),       // writeback loops into the register file
        .i_halted      (o_halt),
        .o_id_ex       (id_ex)
    );

    execute_stage u_execute (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_id_ex    (id_ex),
        .o_ex_mem   (ex_mem),
        .o_redirect (o_redirect)
    );

    result_stage u_result (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_ex_mem (ex_mem),
        .o_wb     (o_wb),
        .o_halt   (o_halt)
    );
endmodule

`default_nettype wire

// ==== tb_mips_core.sv ====
`default_nettype none
`include "mips_cfg.svh"

module tb_mips_core
    import isa_pkg::*;
    import ctrl_pkg::*;
();
    localparam int    WATCHDOG_CYCLES = 5000;
    localparam word_t VICTIM = {OP_ADDI, 5'd0, 5'd8, 16'h007b};   // must be squashed

    logic      clk = 1'b0;
    logic      rst_n;
    word_t     instr_in;
    word_t     pc_in;
    logic      flush_in;
    wb_t       wb_out;
    redirect_t redir_out;
    logic      halt_out;

    word_t      regs [32];           // architectural register model
    logic [7:0] mem_model [1024];    // byte view of data memory
    word_t      pc;
    logic       halted_model;

    always #4 clk = ~clk;

    mips_core dut0 (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_instruction (instr_in),
        .i_pc          (pc_in),
        .i_flush       (flush_in),
        .o_wb          (wb_out),
        .o_redirect    (redir_out),
        .o_halt        (halt_out)
    );

    task automatic abort(input string line);
        $display("%s", line);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_wb(input wb_t got, input wb_t exp, input string what);
        if (got.enable !== exp.enable ||
            (exp.enable && (got.reg_idx !== exp.reg_idx || got.data !== exp.data))) begin
            abort($sformatf("ERR %0t: %s writeback en=%0b r%0d=%h, expected en=%0b r%0d=%h",
                            $time, what, got.enable, got.reg_idx, got.data,
                            exp.enable, exp.reg_idx, exp.data));
        end
    endtask

    task automatic check_redirect(input redirect_t got, input redirect_t exp, input string what);
        if (got.taken !== exp.taken || (exp.taken && got.target !== exp.target)) begin
            abort($sformatf("ERR %0t: %s redirect taken=%0b target=%h, expected %0b %h",
                            $time, what, got.taken, got.target, exp.taken, exp.target));
        end
    endtask

    task automatic check_halt(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort($sformatf("ERR %0t: %s halt=%0b, expected %0b", $time, what, got, exp));
        end
    endtask

    function automatic word_t rtype_word(funct_t fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
                                         shamt_t sh);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t itype_word(opcode_t op, reg_idx_t rs, reg_idx_t rt, imm16_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jump_word(opcode_t op, jidx_t idx);
        return {op, idx};
    endfunction

    function automatic wb_t writeback(reg_idx_t idx, word_t data);
        wb_t w;
        w.enable  = 1'b1;
        w.reg_idx = idx;
        w.data    = data;
        return w;
    endfunction

    function automatic redirect_t jump_to(word_t target);
        redirect_t r;
        r.taken  = 1'b1;
        r.target = target;
        return r;
    endfunction

    // little-endian lane pick with the load's extension
    function automatic word_t lane_value(opcode_t op, word_t addr);
        logic [7:0]  b;
        logic [15:0] h;
        b = mem_model[addr[9:0]];
        h = {mem_model[addr[9:0] + 1], b};
        case (op)
            OP_LB:   return {{24{b[7]}}, b};
            OP_LBU:  return {24'h0, b};
            OP_LH:   return {{16{h[15]}}, h};
            OP_LHU:  return {16'h0, h};
            default: return {mem_model[addr[9:0] + 3], mem_model[addr[9:0] + 2], h};
        endcase
    endfunction

    task automatic issue(input word_t instr, input logic flush);
        @(posedge clk);
        #1;
        instr_in = instr;
        pc_in    = pc;
        flush_in = flush;
        pc       = pc + 4;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        for (int i = 0; i < 8; i++) @(posedge clk);
        #1;
        rst_n        = 1'b1;
        halted_model = 1'b0;
        check_wb(wb_out, '0, "reset");
        check_redirect(redir_out, '0, "reset");
        check_halt(halt_out, 1'b0, "reset");
    endtask

    // redirect due after edge 1, writeback after edge 2; follower lands in the squash slot
    task automatic run_instr(input word_t instr, input logic flush, input word_t follow,
                             input wb_t exp_wb_in, input redirect_t exp_rd_in,
                             input string what);
        wb_t       exp_wb;
        redirect_t exp_rd;
        logic      stops;
        exp_wb = exp_wb_in;
        exp_rd = exp_rd_in;
        stops  = (instr == `HALT_INSTR) && !flush && !halted_model;
        if (flush || halted_model) begin   // decode turns it into a nop
            exp_wb = '0;
            exp_rd = '0;
        end
        issue(instr, flush);
        for (int cyc = 0; cyc < 5; cyc++) begin
            issue((cyc == 1) ? follow : word_t'(0), 1'b0);
            check_redirect(redir_out, (cyc == 1) ? exp_rd : redirect_t'(0), what);
            check_wb(wb_out, (cyc == 2) ? exp_wb : wb_t'(0), what);
            check_halt(halt_out, halted_model || (stops && cyc >= 2), what);
        end
        if (stops) halted_model = 1'b1;
        if (exp_rd.taken) pc = exp_rd.target;   // fetch follows the jump
    endtask

    task automatic write_expect(input word_t instr, input reg_idx_t dest, input word_t value,
                                input string what);
        run_instr(instr, 1'b0, '0, writeback(dest, value), '0, what);
        if (dest != '0 && !halted_model) regs[dest] = value;
    endtask

    task automatic set_reg(input reg_idx_t r, input word_t value);
        write_expect(itype_word(OP_LUI, 5'd0, r, value[31:16]), r, {value[31:16], 16'h0}, "lui");
        write_expect(itype_word(OP_ORI, r, r, value[15:0]), r, value, "ori");
    endtask

    task automatic store(input opcode_t op, input reg_idx_t base, input imm16_t off,
                         input reg_idx_t src, input logic flush);
        word_t addr;
        word_t data;
        addr = regs[base] + {{16{off[15]}}, off};
        data = regs[src];
        run_instr(itype_word(op, base, src, off), flush, '0, '0, '0, "store");
        if (!flush && !halted_model) begin
            mem_model[addr[9:0]] = data[7:0];
            if (op != OP_SB) mem_model[addr[9:0] + 1] = data[15:8];
            if (op == OP_SW) begin
                mem_model[addr[9:0] + 2] = data[23:16];
                mem_model[addr[9:0] + 3] = data[31:24];
            end
        end
    endtask

    task automatic load_check(input opcode_t op, input reg_idx_t base, input imm16_t off,
                              input reg_idx_t dest);
        word_t addr;
        addr = regs[base] + {{16{off[15]}}, off};
        write_expect(itype_word(op, base, dest, off), dest, lane_value(op, addr), "load");
    endtask

    task automatic branch(input opcode_t op, input reg_idx_t rs, input reg_idx_t rt,
                          input logic taken);
        imm16_t    off;
        redirect_t rd;
        off = imm16_t'($urandom % 64) - 16'd32;
        rd  = '0;
        if (taken) rd = jump_to(pc + 4 + {{14{off[15]}}, off, 2'b00});
        run_instr(itype_word(op, rs, rt, off), 1'b0, taken ? VICTIM : word_t'(0), '0, rd,
                  "branch");
    endtask

    task automatic alu_ops();
        word_t  a;
        word_t  b;
        imm16_t k;
        word_t  ks;
        shamt_t sh;
        set_reg(5'd10, $urandom);
        set_reg(5'd11, $urandom);
        a  = regs[10];
        b  = regs[11];
        k  = imm16_t'($urandom);
        ks = {{16{k[15]}}, k};
        sh = shamt_t'($urandom);
        write_expect(rtype_word(FN_ADDU, 5'd10, 5'd11, 5'd12, 5'd0), 5'd12, a + b, "addu");
        write_expect(rtype_word(FN_SUBU, 5'd10, 5'd11, 5'd13, 5'd0), 5'd13, a - b, "subu");
        write_expect(rtype_word(FN_AND, 5'd10, 5'd11, 5'd14, 5'd0), 5'd14, a & b, "and");
        write_expect(rtype_word(FN_OR, 5'd10, 5'd11, 5'd15, 5'd0), 5'd15, a | b, "or");
        write_expect(rtype_word(FN_XOR, 5'd10, 5'd11, 5'd16, 5'd0), 5'd16, a ^ b, "xor");
        write_expect(rtype_word(FN_SLT, 5'd10, 5'd11, 5'd17, 5'd0), 5'd17,
                     word_t'($signed(a) < $signed(b)), "slt");
        write_expect(rtype_word(FN_SLL, 5'd0, 5'd11, 5'd18, sh), 5'd18, b << sh, "sll");
        write_expect(rtype_word(FN_SRL, 5'd0, 5'd11, 5'd19, sh), 5'd19, b >> sh, "srl");
        write_expect(itype_word(OP_ADDI, 5'd10, 5'd20, k), 5'd20, a + ks, "addi");
        write_expect(itype_word(OP_SLTI, 5'd10, 5'd21, k), 5'd21,
                     word_t'($signed(a) < $signed(ks)), "slti");
        write_expect(itype_word(OP_ANDI, 5'd10, 5'd22, k), 5'd22, a & {16'h0, k}, "andi");
        write_expect(itype_word(OP_ORI, 5'd10, 5'd23, k), 5'd23, a | {16'h0, k}, "ori");
        write_expect(itype_word(OP_XORI, 5'd10, 5'd24, k), 5'd24, a ^ {16'h0, k}, "xori");
        write_expect(itype_word(OP_LUI, 5'd0, 5'd25, k), 5'd25, {k, 16'h0}, "lui");
        write_expect(itype_word(OP_ADDI, 5'd10, 5'd0, k), 5'd0, a + ks, "addi to r0");
        write_expect(rtype_word(FN_OR, 5'd0, 5'd0, 5'd26, 5'd0), 5'd26, '0, "read r0");
    endtask

    task automatic memory_lanes();
        set_reg(5'd1, ($urandom % 256) * 4);   // aligned word address
        set_reg(5'd2, $urandom);
        set_reg(5'd3, $urandom);
        store(OP_SW, 5'd1, 16'h0, 5'd2, 1'b0);
        store(OP_SB, 5'd1, imm16_t'($urandom % 4), 5'd3, 1'b0);
        set_reg(5'd3, $urandom);
        store(OP_SH, 5'd1, imm16_t'(($urandom % 2) * 2), 5'd3, 1'b0);
        for (int i = 0; i < 4; i++) begin
            load_check(OP_LB, 5'd1, imm16_t'(i), 5'd4);
            load_check(OP_LBU, 5'd1, imm16_t'(i), 5'd4);
        end
        for (int i = 0; i < 4; i += 2) begin
            load_check(OP_LH, 5'd1, imm16_t'(i), 5'd5);
            load_check(OP_LHU, 5'd1, imm16_t'(i), 5'd5);
        end
        load_check(OP_LW, 5'd1, 16'h0, 5'd6);
        load_check(OP_LWU, 5'd1, 16'h0, 5'd6);
    endtask

    task automatic control_flow();
        jidx_t idx;
        word_t link;
        set_reg(5'd4, $urandom);
        set_reg(5'd5, regs[4]);
        set_reg(5'd6, regs[4] ^ 32'h0000_0100);
        branch(OP_BEQ, 5'd4, 5'd5, 1'b1);
        branch(OP_BEQ, 5'd4, 5'd6, 1'b0);
        branch(OP_BNE, 5'd4, 5'd6, 1'b1);
        branch(OP_BNE, 5'd4, 5'd5, 1'b0);
        idx  = jidx_t'($urandom);
        link = pc + 4;
        run_instr(jump_word(OP_J, idx), 1'b0, VICTIM, '0,
                  jump_to({link[31:28], idx, 2'b00}), "j");
        idx  = jidx_t'($urandom);
        link = pc + 4;
        run_instr(jump_word(OP_JAL, idx), 1'b0, VICTIM, writeback(`LINK_REG, link),
                  jump_to({link[31:28], idx, 2'b00}), "jal");
        regs[31] = link;
        set_reg(5'd7, $urandom & 32'hFFFF_FFFC);
        run_instr(rtype_word(FN_JR, 5'd7, 5'd0, 5'd0, 5'd0), 1'b0, VICTIM, '0,
                  jump_to(regs[7]), "jr");
        set_reg(5'd7, $urandom & 32'hFFFF_FFFC);
        link = pc + 4;
        run_instr(rtype_word(FN_JALR, 5'd7, 5'd0, `LINK_REG, 5'd0), 1'b0, VICTIM,
                  writeback(`LINK_REG, link), jump_to(regs[7]), "jalr");
        regs[31] = link;
    endtask

    task automatic flush_and_nop();
        set_reg(5'd2, $urandom);
        store(OP_SW, 5'd1, 16'h0, 5'd2, 1'b0);
        set_reg(5'd2, ~regs[2]);
        store(OP_SW, 5'd1, 16'h0, 5'd2, 1'b1);   // must leave memory alone
        run_instr(itype_word(OP_ADDI, 5'd0, 5'd9, 16'h0055), 1'b1, '0, '0, '0, "flushed addi");
        run_instr(jump_word(OP_J, jidx_t'($urandom)), 1'b1, '0, '0, '0, "flushed j");
        run_instr('0, 1'b0, '0, '0, '0, "nop");
        load_check(OP_LW, 5'd1, 16'h0, 5'd9);
    endtask

    task automatic halt_sequence();
        run_instr(`HALT_INSTR, 1'b0, '0, '0, '0, "halt");
        write_expect(itype_word(OP_ADDI, 5'd0, 5'd9, 16'h0011), 5'd9, 32'h11, "after halt");
        apply_reset();
        write_expect(itype_word(OP_ADDI, 5'd0, 5'd9, 16'h0011), 5'd9, 32'h11, "after reset");
    endtask

    initial begin
        for (int i = 0; i < WATCHDOG_CYCLES; i++) @(posedge clk);
        abort("timeout: the test sequence did not finish in time");
    end

    initial begin
        rst_n        = 1'b0;
        instr_in     = '0;
        pc_in        = '0;
        flush_in     = 1'b0;
        pc           = 32'h0000_1000;
        halted_model = 1'b0;
        regs[0]      = '0;
        void'($urandom(22213));
        apply_reset();
        alu_ops();
        memory_lanes();
        control_flow();
        flush_and_nop();
        halt_sequence();
        $display("Simulation finished: PASS");
        $finish;
    end
endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
isa_pkg.sv
ctrl_pkg.sv
control_unit.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
mips_core.sv
tb_mips_core.sv
